/* hw/memif_pkg.sv */
package memif_pkg;

	// data and address buses are both one 16-bit word wide
	localparam int WORD_W = 16;
	localparam int ADDR_W = 16;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// command codes seen on the cpu side
	typedef logic [1:0] op_t;

	localparam op_t OP_READ  = 2'd0;
	localparam op_t OP_WRITE = 2'd1;
	// add-to-memory, returns the old word and stores old plus operand
	localparam op_t OP_ADD   = 2'd2;
	// set-if-zero, stores the operand only when the old word is zero
	localparam op_t OP_SETZ  = 2'd3;

	// how a memory cycle ended
	typedef logic [1:0] status_t;

	localparam status_t ST_OK    = 2'd0;
	localparam status_t ST_EN    = 2'd1;
	localparam status_t ST_ALARM = 2'd2;

	// states of the command sequencer
	typedef enum logic [2:0] {S_IDLE, S_CLAIM, S_PHASE, S_GAP, S_DONE} seq_state_t;

	// cycles a bus phase may stay unanswered before the alarm fires
	localparam int ALARM_DLY_TICKS = 32;
	// length of the alarm pulse in cycles
	localparam int ALARM_TICKS = 4;

	// counter widths for the no-answer timer
	localparam int DLY_CNT_W  = $clog2(ALARM_DLY_TICKS + 1);
	localparam int HOLD_CNT_W = $clog2(ALARM_TICKS + 1);

	typedef logic [DLY_CNT_W-1:0] dly_cnt_t;
	typedef logic [HOLD_CNT_W-1:0] hold_cnt_t;

endpackage

/* hw/cmd_seq.sv */
`timescale 1ns/1ps

module cmd_seq (
	input logic clk_sys,
	input logic clo,
	input logic cmd_valid,
	input memif_pkg::op_t cmd_op,
	input memif_pkg::addr_t cmd_addr,
	input memif_pkg::word_t cmd_wdata,
	output logic cmd_ready,
	input logic ok_end,
	input logic talarm,
	input logic rok,
	input logic ren,
	input memif_pkg::word_t rd_word,
	output logic zgi_set,
	output logic gotst1,
	output logic zgi_j,
	output logic ifhold_j,
	output logic ifhold_reset,
	output logic ph_we,
	output memif_pkg::addr_t ph_addr,
	output memif_pkg::word_t ph_wdata,
	output logic rsp_valid,
	output memif_pkg::word_t rsp_data,
	output memif_pkg::status_t rsp_status
);
	import memif_pkg::*;

	seq_state_t state;
	op_t op_q;
	word_t opnd_q;
	// word seen in the read phase of add or set-if-zero
	word_t old_q;
	logic rmw_q;
	logic wr_ph_q;
	status_t st_now;
	logic go_on;

	// a new command is only taken while nothing is in flight
	assign cmd_ready = (state == S_IDLE);
	// the request flip-flop in if_ctl is set once per phase from here
	assign zgi_set = (state == S_CLAIM);
	assign zgi_j = rmw_q;
	// only the read half of a read-modify-write arms the hold
	assign ifhold_j = rmw_q & ~wr_ph_q;

	// an alarm can coincide with a late answer, the answer wins then
	always_comb begin
		st_now = talarm ? ST_ALARM : ST_OK;
		if (ren)
			st_now = ST_EN;
		if (rok)
			st_now = ST_OK;
	end

	// the write phase follows only a clean read, and set-if-zero needs a zero word
	assign go_on = rmw_q & ~wr_ph_q & rok & ~((op_q == OP_SETZ) && (rd_word != '0));

	always_ff @(posedge clk_sys or posedge clo) begin
		if (clo) begin
			state <= S_IDLE;
			gotst1 <= 1'b0;
			ifhold_reset <= 1'b0;
			rsp_valid <= 1'b0;
			rmw_q <= 1'b0;
			wr_ph_q <= 1'b0;
			ph_we <= 1'b0;
		end else begin
			gotst1 <= 1'b0;
			ifhold_reset <= 1'b0;
			rsp_valid <= 1'b0;
			unique case (state)
				S_IDLE: begin
					if (cmd_valid) begin
						ph_we <= (cmd_op == OP_WRITE);
						rmw_q <= (cmd_op == OP_ADD) || (cmd_op == OP_SETZ);
						wr_ph_q <= 1'b0;
						state <= S_CLAIM;
					end
				end
				S_CLAIM: state <= S_PHASE;
				S_PHASE: begin
					if (ok_end) begin
						// every phase end is acknowledged with one gotst1 pulse
						gotst1 <= 1'b1;
						if (go_on) begin
							ph_we <= 1'b1;
							wr_ph_q <= 1'b1;
							state <= S_GAP;
						end else begin
							// a read-modify-write that stops after its read must drop the hold
							ifhold_reset <= rmw_q & ~wr_ph_q;
							state <= S_DONE;
						end
					end
				end
				S_GAP: state <= S_CLAIM;
				S_DONE: begin
					rsp_valid <= 1'b1;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// command payload and result words
	always_ff @(posedge clk_sys) begin
		if ((state == S_IDLE) && cmd_valid) begin
			op_q <= cmd_op;
			opnd_q <= cmd_wdata;
			ph_addr <= cmd_addr;
			ph_wdata <= cmd_wdata;
		end
		if ((state == S_PHASE) && ok_end) begin
			if (go_on) begin
				old_q <= rd_word;
				ph_wdata <= (op_q == OP_ADD) ? word_t'(rd_word + opnd_q) : opnd_q;
			end else begin
				rsp_status <= st_now;
				rsp_data <= wr_ph_q ? old_q : rd_word;
			end
		end
	end

endmodule

/* hw/if_ctl.sv */
`timescale 1ns/1ps

module if_ctl (
	input logic clk_sys,
	input logic clo,
	input logic gotst1,
	input logic zgi_j,
	input logic zgi_set,
	input logic ifhold_j,
	input logic ifhold_reset,
	input logic zw,
	input logic ren,
	input logic rok,
	input logic talarm,
	output logic ok_end,
	output logic zg,
	output logic zwzg,
	output logic engage
);

	logic zgi;
	logic ifhold;
	logic oken;
	logic ifh_clr;

	// any registered slave answer
	assign oken = ren | rok;

	// the phase is live on the bus only while we ask and the arbiter grants
	assign zwzg = zgi & zw;

	// the claim covers the active request, the hold between the two halves of
	// an atomic access, and a granted bus whose answer has not dropped yet
	assign zg = zgi | ifhold | (zw & oken);

	// end of the phase whatever the outcome, answer or alarm
	assign ok_end = zwzg & (oken | talarm);

	// the no-answer timer runs only while the phase waits on the bus
	assign engage = zwzg & ~ok_end;

	// request flip-flop
	// zgi_set opens the request, gotst1 closes it or flips it when zgi_j is up
	always_ff @(posedge clk_sys or posedge clo) begin
		if (clo)
			zgi <= 1'b0;
		else if (zgi_set)
			zgi <= 1'b1;
		else if (gotst1)
			zgi <= zgi_j ? ~zgi : 1'b0;
	end

	// hold flip-flop, a jk stage clocked by the phase end
	// it spans the gap between the read and the write of add and set-if-zero
	assign ifh_clr = clo | ifhold_reset;

	always_ff @(posedge clk_sys or posedge ifh_clr) begin
		if (ifh_clr) begin
			ifhold <= 1'b0;
		end else if (ok_end) begin
			unique case ({ifhold_j, ifhold})
				2'b00: ifhold <= 1'b0;
				2'b01: ifhold <= 1'b0;
				2'b10: ifhold <= 1'b1;
				2'b11: ifhold <= 1'b0;
				default: ifhold <= 1'b0;
			endcase
		end
	end

endmodule

/* hw/if_alarm.sv */
`timescale 1ns/1ps

module if_alarm (
	input logic clk_sys,
	input logic clo,
	input logic engage,
	output logic talarm
);
	import memif_pkg::*;

	dly_cnt_t dly_cnt;
	hold_cnt_t hold_cnt;
	logic fire;

	// the delay expires on the last of ALARM_DLY_TICKS unbroken engaged cycles
	assign fire = engage && (dly_cnt == dly_cnt_t'(1));

	// delay counter, reloaded as soon as engage drops
	always_ff @(posedge clk_sys or posedge clo) begin
		if (clo)
			dly_cnt <= dly_cnt_t'(ALARM_DLY_TICKS);
		else if (!engage)
			dly_cnt <= dly_cnt_t'(ALARM_DLY_TICKS);
		else if (dly_cnt != '0)
			dly_cnt <= dly_cnt - dly_cnt_t'(1);
	end

	// stretch counter keeps the alarm up for ALARM_TICKS cycles
	always_ff @(posedge clk_sys or posedge clo) begin
		if (clo)
			hold_cnt <= '0;
		else if (fire)
			hold_cnt <= hold_cnt_t'(ALARM_TICKS);
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - hold_cnt_t'(1);
	end

	// decoded straight from the counter register, so no glitches
	assign talarm = (hold_cnt != '0);

endmodule

/* hw/bus_port.sv */
`timescale 1ns/1ps

module bus_port (
	input logic clk_sys,
	input logic clo,
	input logic zwzg,
	input logic ph_we,
	input memif_pkg::addr_t ph_addr,
	input memif_pkg::word_t ph_wdata,
	output logic bus_req,
	output logic bus_we,
	output memif_pkg::addr_t bus_addr,
	output memif_pkg::word_t bus_wdata,
	input logic bus_ok,
	input logic bus_en,
	input memif_pkg::word_t bus_rdata,
	output logic rok,
	output logic ren,
	output memif_pkg::word_t rd_word
);
	import memif_pkg::*;

	logic ans_ok;
	logic ans_en;

	// the request goes out as soon as we are granted
	assign bus_req = zwzg;

	// answers count only while our request is on the bus
	assign ans_ok = bus_ok & zwzg;
	assign ans_en = bus_en & zwzg;

	// direction follows the sequencer between phases and freezes during one
	always_ff @(posedge clk_sys or posedge clo) begin
		if (clo)
			bus_we <= 1'b0;
		else if (!zwzg)
			bus_we <= ph_we;
	end

	// address and data are loaded the same way so the slave sees them steady
	always_ff @(posedge clk_sys) begin
		if (!zwzg) begin
			bus_addr <= ph_addr;
			bus_wdata <= ph_wdata;
		end
	end

	// slave answers become one-cycle pulses toward if_ctl
	always_ff @(posedge clk_sys or posedge clo) begin
		if (clo) begin
			rok <= 1'b0;
			ren <= 1'b0;
		end else begin
			rok <= ans_ok;
			ren <= ans_en;
		end
	end

	// read word is valid in the cycle where rok is high
	always_ff @(posedge clk_sys) begin
		if (ans_ok)
			rd_word <= word_t'(bus_rdata);
	end

endmodule

/* hw/memif_top.sv */
`timescale 1ns/1ps

module memif_top (
	input logic clk_sys,
	input logic clo,
	input logic cmd_valid,
	input memif_pkg::op_t cmd_op,
	input memif_pkg::addr_t cmd_addr,
	input memif_pkg::word_t cmd_wdata,
	output logic cmd_ready,
	output logic rsp_valid,
	output memif_pkg::word_t rsp_data,
	output memif_pkg::status_t rsp_status,
	output logic bus_claim,
	input logic bus_gnt,
	output logic bus_req,
	output logic bus_we,
	output memif_pkg::addr_t bus_addr,
	output memif_pkg::word_t bus_wdata,
	input logic bus_ok,
	input logic bus_en,
	input memif_pkg::word_t bus_rdata
);
	import memif_pkg::*;

	// sequencer to request logic
	logic zgi_set;
	logic gotst1;
	logic zgi_j;
	logic ifhold_j;
	logic ifhold_reset;
	// phase contents toward the bus side
	logic ph_we;
	addr_t ph_addr;
	word_t ph_wdata;
	// registered slave answers
	logic rok;
	logic ren;
	word_t rd_word;
	// request logic outputs and the timer
	logic ok_end;
	logic zwzg;
	logic engage;
	logic talarm;

	cmd_seq cmd_seq_inst (
		.clk_sys(clk_sys), .clo(clo),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr),
		.cmd_wdata(cmd_wdata), .cmd_ready(cmd_ready),
		.ok_end(ok_end), .talarm(talarm), .rok(rok), .ren(ren), .rd_word(rd_word),
		.zgi_set(zgi_set), .gotst1(gotst1), .zgi_j(zgi_j),
		.ifhold_j(ifhold_j), .ifhold_reset(ifhold_reset),
		.ph_we(ph_we), .ph_addr(ph_addr), .ph_wdata(ph_wdata),
		.rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_status(rsp_status)
	);

	// the arbiter grant is the zw input, the claim goes back out as zg
	if_ctl if_ctl_inst (
		.clk_sys(clk_sys), .clo(clo),
		.gotst1(gotst1), .zgi_j(zgi_j), .zgi_set(zgi_set),
		.ifhold_j(ifhold_j), .ifhold_reset(ifhold_reset),
		.zw(bus_gnt), .ren(ren), .rok(rok), .talarm(talarm),
		.ok_end(ok_end), .zg(bus_claim), .zwzg(zwzg), .engage(engage)
	);

	if_alarm if_alarm_inst (
		.clk_sys(clk_sys), .clo(clo), .engage(engage), .talarm(talarm)
	);

	bus_port bus_port_inst (
		.clk_sys(clk_sys), .clo(clo), .zwzg(zwzg),
		.ph_we(ph_we), .ph_addr(ph_addr), .ph_wdata(ph_wdata),
		.bus_req(bus_req), .bus_we(bus_we), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
		.bus_ok(bus_ok), .bus_en(bus_en), .bus_rdata(bus_rdata),
		.rok(rok), .ren(ren), .rd_word(rd_word)
	);

endmodule

/* sim/tb_clk.sv */
`timescale 1ns/1ps

module tb_clk (
	output logic clk_sys
);

	// 8 ns period, the first rising edge comes at 4 ns
	localparam time HALF_PERIOD = 4ns;

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD) clk_sys = ~clk_sys;
	end

endmodule

/* sim/memif_tb.sv */
`timescale 1ns/1ps

module memif_tb;
	import memif_pkg::*;

	// address map of the slave model
	localparam int MEM_WORDS = 64;
	localparam int EN_BASE = 48;
	localparam int DEAD_ADDR = 63;
	localparam int NUM_RANDOM = 300;
	// longest wait for one handshake including the alarm path
	localparam int CMD_TIMEOUT = 400;

	logic clk_sys;
	logic clo;
	logic cmd_valid;
	op_t cmd_op;
	addr_t cmd_addr;
	word_t cmd_wdata;
	logic cmd_ready;
	logic rsp_valid;
	word_t rsp_data;
	status_t rsp_status;
	logic bus_claim;
	logic bus_gnt = 1'b0;
	logic bus_req;
	logic bus_we;
	addr_t bus_addr;
	word_t bus_wdata;
	logic bus_ok = 1'b0;
	logic bus_en = 1'b0;
	word_t bus_rdata = '0;

	// bus timing drawn afresh for every command
	logic [1:0] gnt_dly = '0;
	logic gnt_park = 1'b0;
	logic [1:0] slv_lat = '0;
	logic [1:0] gnt_cnt = '0;
	logic [1:0] lat_cnt = '0;
	logic answered = 1'b0;
	word_t slv_mem [MEM_WORDS];
	word_t model_mem [MEM_WORDS];
	logic [31:0] rng_state;
	int cmd_count;
	// running totals kept by the bus monitor
	int req_cycles = 0;
	int wr_phases = 0;
	int rsp_count = 0;
	logic req_prev = 1'b0;
	logic watch_add = 1'b0;
	logic add_seen_req = 1'b0;
	logic add_wr_done = 1'b0;

	tb_clk tb_clk_inst (.clk_sys(clk_sys));

	memif_top memif_top_inst (
		.clk_sys(clk_sys), .clo(clo),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr),
		.cmd_wdata(cmd_wdata), .cmd_ready(cmd_ready),
		.rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_status(rsp_status),
		.bus_claim(bus_claim), .bus_gnt(bus_gnt), .bus_req(bus_req), .bus_we(bus_we),
		.bus_addr(bus_addr), .bus_wdata(bus_wdata),
		.bus_ok(bus_ok), .bus_en(bus_en), .bus_rdata(bus_rdata)
	);

	// every bit of the index takes part in the start-up contents
	function automatic word_t fill_word(input int idx);
		logic [15:0] a;
		a = 16'(idx);
		return (a * 16'h9e37) ^ {a[7:0], a[15:8]} ^ 16'h3c5a;
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic draw(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input word_t exp_val, input word_t act_val);
		if (act_val !== exp_val)
			abort_run($sformatf("ERR %s: expected %h, got %h", name, exp_val, act_val));
	endtask

	task automatic check_status(input string name, input status_t exp_val,
			input status_t act_val);
		if (act_val !== exp_val)
			abort_run($sformatf("ERR %s: expected %0d, got %0d", name, exp_val, act_val));
	endtask

	task automatic check_flag(input string name, input logic exp_val, input logic act_val);
		if (act_val !== exp_val)
			abort_run($sformatf("ERR %s: expected %b, got %b", name, exp_val, act_val));
	endtask

	// the arbiter grants after a random delay and holds the grant while claimed
	always @(posedge clk_sys) begin
		if (clo) begin
			bus_gnt <= 1'b0;
			gnt_cnt <= '0;
		end else if (!bus_claim) begin
			// a parked grant stays up with no claim at all
			bus_gnt <= gnt_park;
			gnt_cnt <= gnt_dly;
		end else if (!bus_gnt) begin
			if (gnt_cnt == 2'd0)
				bus_gnt <= 1'b1;
			else
				gnt_cnt <= gnt_cnt - 2'd1;
		end
	end

	// the memory slave gives one answer per request and only while bus_req is up
	always @(posedge clk_sys) begin
		if (clo) begin
			for (int i = 0; i < MEM_WORDS; i++)
				slv_mem[i] = fill_word(i);
			bus_ok <= 1'b0;
			bus_en <= 1'b0;
			answered <= 1'b0;
			lat_cnt <= '0;
		end else begin
			bus_ok <= 1'b0;
			bus_en <= 1'b0;
			if (!bus_req) begin
				answered <= 1'b0;
				lat_cnt <= slv_lat;
			end else if (!answered && (int'(bus_addr) != DEAD_ADDR)) begin
				if (lat_cnt != 2'd0) begin
					lat_cnt <= lat_cnt - 2'd1;
				end else begin
					answered <= 1'b1;
					if (int'(bus_addr) >= EN_BASE) begin
						bus_en <= 1'b1;
					end else begin
						// the old word goes back even on a write
						bus_ok <= 1'b1;
						bus_rdata <= slv_mem[bus_addr[5:0]];
						if (bus_we)
							slv_mem[bus_addr[5:0]] = bus_wdata;
					end
				end
			end
		end
	end

	// the bus monitor counts phases and watches the grant and the atomic claim
	always @(posedge clk_sys) begin
		if (!clo) begin
			if (bus_req && !bus_gnt)
				abort_run("bus_req was high while bus_gnt was low");
			if (bus_req)
				req_cycles <= req_cycles + 1;
			// a phase starts where bus_req rises and bus_we is already steady there
			if (bus_req && !req_prev && bus_we)
				wr_phases <= wr_phases + 1;
			if (rsp_valid)
				rsp_count <= rsp_count + 1;
			req_prev <= bus_req;
			if (watch_add) begin
				if (bus_req)
					add_seen_req <= 1'b1;
				if ((add_seen_req || bus_req) && !add_wr_done && !bus_claim)
					abort_run("bus_claim dropped between the read and write of an ADD");
				if (bus_ok && bus_we)
					add_wr_done <= 1'b1;
			end else begin
				add_seen_req <= 1'b0;
				add_wr_done <= 1'b0;
			end
		end
	end

	// issues one command, predicts its result and checks it
	task automatic run_cmd(input op_t op, input addr_t addr, input word_t wdata);
		logic [31:0] r;
		word_t old_word;
		word_t exp_data;
		status_t exp_st;
		logic exp_wr;
		logic check_data;
		int idx;
		int req0;
		int wr0;
		int rsp0;
		int waited;
		string tag;
		idx = int'(addr);
		old_word = model_mem[idx];
		exp_data = old_word;
		exp_wr = (op == OP_WRITE);
		check_data = 1'b1;
		tag = $sformatf("cmd %0d op %0d addr %0d", cmd_count, op, addr);
		// expected outcome straight from the address map and the op rules
		if (idx == DEAD_ADDR) begin
			exp_st = ST_ALARM;
			check_data = 1'b0;
		end else if (idx >= EN_BASE) begin
			exp_st = ST_EN;
			check_data = 1'b0;
		end else begin
			exp_st = ST_OK;
			case (op)
				OP_READ: exp_data = old_word;
				OP_WRITE: begin
					model_mem[idx] = wdata;
					check_data = 1'b0;
				end
				OP_ADD: begin
					model_mem[idx] = old_word + wdata;
					exp_wr = 1'b1;
				end
				default: begin
					if (old_word == '0) begin
						model_mem[idx] = wdata;
						exp_wr = 1'b1;
					end
				end
			endcase
		end
		@(posedge clk_sys);
		draw(r);
		gnt_dly <= r[1:0];
		gnt_park <= r[2] & r[3];
		slv_lat <= r[5:4];
		watch_add <= (op == OP_ADD) && (idx < EN_BASE);
		req0 = req_cycles;
		wr0 = wr_phases;
		rsp0 = rsp_count;
		cmd_valid <= 1'b1;
		cmd_op <= op;
		cmd_addr <= addr;
		cmd_wdata <= wdata;
		waited = 0;
		forever begin
			@(posedge clk_sys);
			if (cmd_ready)
				break;
			waited++;
			if (waited >= CMD_TIMEOUT)
				abort_run($sformatf("%s was never accepted", tag));
		end
		cmd_valid <= 1'b0;
		cmd_count++;
		waited = 0;
		forever begin
			@(posedge clk_sys);
			if (rsp_valid)
				break;
			// no new command may be taken before the result is out
			check_flag({tag, " cmd_ready while busy"}, 1'b0, cmd_ready);
			waited++;
			if (waited >= CMD_TIMEOUT)
				abort_run($sformatf("%s got no response", tag));
		end
		watch_add <= 1'b0;
		check_status({tag, " status"}, exp_st, rsp_status);
		if (check_data)
			check_word({tag, " data"}, exp_data, rsp_data);
		if (idx < MEM_WORDS)
			check_word({tag, " memory"}, model_mem[idx], slv_mem[idx]);
		check_flag({tag, " write phase"}, exp_wr, (wr_phases - wr0) > 0);
		check_flag({tag, " single write phase"}, 1'b1, (wr_phases - wr0) <= 1);
		check_flag({tag, " bus_claim released"}, 1'b0, bus_claim);
		check_flag({tag, " bus_req released"}, 1'b0, bus_req);
		check_flag({tag, " no early response"}, 1'b1, rsp_count == rsp0);
		if (exp_st == ST_ALARM)
			check_flag({tag, " alarm delay"}, 1'b1, (req_cycles - req0) >= ALARM_DLY_TICKS);
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] r2;
		addr_t addr;
		word_t data;
		rng_state = 32'd98433;
		cmd_count = 0;
		clo = 1'b1;
		cmd_valid = 1'b0;
		cmd_op = OP_READ;
		cmd_addr = '0;
		cmd_wdata = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			model_mem[i] = fill_word(i);
		repeat (2) @(posedge clk_sys);
		clo <= 1'b0;
		@(posedge clk_sys);
		check_flag("reset cmd_ready", 1'b1, cmd_ready);
		check_flag("reset rsp_valid", 1'b0, rsp_valid);
		check_flag("reset bus_claim", 1'b0, bus_claim);
		check_flag("reset bus_req", 1'b0, bus_req);
		// write then read back, then the atomic ops on known words
		run_cmd(OP_WRITE, 16'd5, 16'h1234);
		run_cmd(OP_READ, 16'd5, 16'h0000);
		run_cmd(OP_ADD, 16'd5, 16'h0101);
		run_cmd(OP_READ, 16'd5, 16'h0000);
		run_cmd(OP_WRITE, 16'd6, 16'h0000);
		run_cmd(OP_SETZ, 16'd6, 16'habcd);
		run_cmd(OP_SETZ, 16'd6, 16'h1111);
		run_cmd(OP_READ, 16'd6, 16'h0000);
		// error map and the silent address
		run_cmd(OP_READ, 16'd50, 16'h0000);
		run_cmd(OP_WRITE, 16'd55, 16'h7777);
		run_cmd(OP_ADD, 16'd49, 16'h0001);
		run_cmd(OP_READ, 16'd63, 16'h0000);
		run_cmd(OP_SETZ, 16'd63, 16'h4444);
		for (int n = 0; n < NUM_RANDOM; n++) begin
			draw(r);
			draw(r2);
			if (r[3:0] == 4'd0)
				addr = addr_t'(DEAD_ADDR);
			else if (r[3:0] < 4'd3)
				addr = addr_t'(EN_BASE + int'(r[7:4]) % 15);
			else if (r[8])
				addr = addr_t'(r[7:4]);
			else
				addr = addr_t'(int'(r[14:9]) % EN_BASE);
			// zero data now and then so set-if-zero finds zero words
			data = (r2[1:0] == 2'd0) ? '0 : r2[31:16];
			run_cmd(op_t'(r[17:16]), addr, data);
			repeat (int'(r2[5:4])) @(posedge clk_sys);
		end
		repeat (4) @(posedge clk_sys);
		if (rsp_count == cmd_count) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			abort_run($sformatf("%0d commands issued but %0d responses",
				cmd_count, rsp_count));
		end
	end

endmodule

/* memif.f */
hw/memif_pkg.sv
hw/cmd_seq.sv
hw/if_ctl.sv
hw/if_alarm.sv
hw/bus_port.sv
hw/memif_top.sv
sim/tb_clk.sv
sim/memif_tb.sv

/* Makefile */
SIM    := verilator
FLAGS  := --binary --timing --timescale 1ns/1ps -j 0
TOP    := memif_tb
FLIST  := memif.f
OBJDIR := obj_dir
LOG    := sim.log

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
